// File: filelist.f
+incdir+hdl
hdl/corr_pkg.sv
hdl/credit_fifo.sv
hdl/corr_sequencer.sv
hdl/bit_corr_chain.sv
hdl/corr_collector.sv
hdl/bit_corr_top.sv
tests/bit_corr_checker.sv
tests/bit_corr_tb.sv

// File: tests/bit_corr_tb.sv
// Bit correlator testbench
`timescale 1ns/1ps
`include "corr_cfg.svh"

module bit_corr_tb
  import corr_pkg::*;
;

  localparam int NP  = `CORR_NUM_PARALLEL;
  localparam int NC  = `CORR_NUM_CORRS;
  localparam int LEN = `CORR_LENGTH;
  localparam logic [NC*LEN-1:0] TAPS = `CORR_TAPS;
  localparam int STREAM_WORDS = 40;
  localparam int HOLD_WORDS   = 16;
  localparam int TOTAL_WORDS  = LEN + STREAM_WORDS + HOLD_WORDS + 2 * (LEN + 1);
  localparam int WATCHDOG_CYCLES = 8 * NP * NC * TOTAL_WORDS + 2000;

  logic      clk = 1'b0;
  logic      arst_n = 1'b0;
  logic      in_valid = 1'b0;
  in_word_t  in_data = '0;
  logic      in_credit;
  logic      out_valid;
  out_word_t out_data;
  code_idx_t out_code;
  logic      out_credit = 1'b0;

  // Sender credit state
  int credits_returned = 0;
  int credits_spent = 0;
  int sent_count = 0;
  // Receiver state
  // Negative budget returns credit without limit
  int credit_budget = -1;
  int owed_credits = 0;
  int rx_total = 0;
  out_word_t rx_words [$];
  code_idx_t rx_codes [$];
  out_word_t exp_words [$];
  code_idx_t exp_codes [$];
  // Per-channel sample history with tap 0 newest
  int hist [NP][LEN];

  bit_corr_top i_bit_corr_top (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_data(in_data),
    .in_credit(in_credit), .out_valid(out_valid), .out_data(out_data),
    .out_code(out_code), .out_credit(out_credit)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Failure handling and compares
  ////////////////////////////////////////////////////////////

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input out_word_t got, input out_word_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("error at %0t: %s word expected %h, got %h",
                                $time, what, exp, got));
    end
  endtask

  task automatic check_code(input code_idx_t got, input code_idx_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("error at %0t: %s code expected %0d, got %0d",
                                $time, what, exp, got));
    end
  endtask

  // Stop once a checker assertion has fired
  always @(posedge clk) begin
    if (i_bit_corr_top.i_checker.assert_fails != 0) begin
      stop_on_failure("A credit or buffer assertion in the checker failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_failure($sformatf("Timeout: tests did not finish in %0d cycles", WATCHDOG_CYCLES));
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Shift in one word and queue one expected word per code
  task automatic model_word(input in_word_t w);
    sample_t   s;
    int        acc;
    out_word_t y;
    for (int p = 0; p < NP; p++) begin
      for (int k = LEN - 1; k > 0; k--) begin
        hist[p][k] = hist[p][k-1];
      end
      s = w[p];
      hist[p][0] = int'(s);
    end
    for (int j = 0; j < NC; j++) begin
      for (int p = 0; p < NP; p++) begin
        acc = 0;
        for (int k = 0; k < LEN; k++) begin
          acc += TAPS[j*LEN+k] ? hist[p][k] : -hist[p][k];
        end
        // Exact sum must fit the output lane
        if (int'(acc_t'(acc)) != acc) begin
          stop_on_failure("Expected sum does not fit the accumulator width");
        end
        y[p] = acc_t'(acc);
      end
      exp_words.push_back(y);
      exp_codes.push_back(code_idx_t'(j));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stream drivers
  ////////////////////////////////////////////////////////////

  // Count returned input credits
  always @(posedge clk) begin
    if (arst_n && in_credit) begin
      credits_returned <= credits_returned + 1;
    end
  end

  // Downstream consumer with credit policy
  always @(posedge clk) begin
    if (!arst_n) begin
      out_credit <= 1'b0;
    end else begin
      if (out_valid) begin
        rx_words.push_back(out_data);
        rx_codes.push_back(out_code);
        rx_total++;
        owed_credits++;
      end
      if (owed_credits > 0 && credit_budget != 0) begin
        out_credit <= 1'b1;
        owed_credits--;
        if (credit_budget > 0) begin
          credit_budget--;
        end
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  // One word per cycle while credit lasts
  task automatic send_word(input in_word_t w);
    while (`CORR_IN_DEPTH + credits_returned - credits_spent <= 0) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_data  <= w;
    credits_spent++;
    sent_count++;
    model_word(w);
    @(posedge clk);
  endtask

  function automatic in_word_t rand_word();
    in_word_t w;
    for (int p = 0; p < NP; p++) begin
      w[p] = sample_t'($urandom);
    end
    return w;
  endfunction

  function automatic in_word_t fill_word(input sample_t v);
    in_word_t w;
    for (int p = 0; p < NP; p++) begin
      w[p] = v;
    end
    return w;
  endfunction

  task automatic wait_results(input int n);
    while (rx_words.size() < n) begin
      @(posedge clk);
    end
  endtask

  // Drain and compare in order
  task automatic compare_results(input string what);
    wait_results(exp_words.size());
    while (exp_words.size() > 0) begin
      check_word(rx_words.pop_front(), exp_words.pop_front(), what);
      check_code(rx_codes.pop_front(), exp_codes.pop_front(), what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_idle();
    repeat (20) begin
      @(posedge clk);
      if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
        stop_on_failure("out_valid or in_credit went high with no input");
      end
    end
    if (rx_words.size() != 0) begin
      stop_on_failure("Output words appeared with no input");
    end
  endtask

  task automatic test_impulse();
    in_word_t  w;
    out_word_t pat;
    for (int p = 0; p < NP; p++) begin
      w[p] = sample_t'(p + 1);
    end
    send_word(w);
    for (int t = 1; t < LEN; t++) begin
      send_word('0);
    end
    in_valid <= 1'b0;
    wait_results(LEN * NC);
    // Word t, code j carries tap t of code j scaled by the impulse
    for (int t = 0; t < LEN; t++) begin
      for (int j = 0; j < NC; j++) begin
        for (int p = 0; p < NP; p++) begin
          pat[p] = TAPS[j*LEN+t] ? acc_t'(p + 1) : -acc_t'(p + 1);
        end
        check_word(rx_words[t*NC+j], pat, "impulse pattern");
        check_code(rx_codes[t*NC+j], code_idx_t'(j), "impulse pattern");
      end
    end
    compare_results("impulse");
  endtask

  task automatic test_random_stream();
    for (int i = 0; i < STREAM_WORDS; i++) begin
      send_word(rand_word());
    end
    in_valid <= 1'b0;
    compare_results("random stream");
  endtask

  task automatic test_backpressure();
    int rx_base;
    int sent_base;
    int quiet;
    rx_base   = rx_total;
    sent_base = sent_count;
    credit_budget = 2;
    fork
      begin
        for (int i = 0; i < HOLD_WORDS; i++) begin
          send_word(rand_word());
        end
        in_valid <= 1'b0;
      end
    join_none
    // Wait for the input side to go quiet
    quiet = 0;
    while (quiet < 40) begin
      @(posedge clk);
      quiet = in_credit ? 0 : quiet + 1;
    end
    if (rx_total - rx_base - 2 > `CORR_OUT_CREDITS) begin
      stop_on_failure("More words arrived than downstream credits allowed");
    end
    if (sent_count - sent_base >= HOLD_WORDS) begin
      stop_on_failure("Input credits kept flowing while output was held");
    end
    credit_budget = -1;
    wait fork;
    compare_results("back-pressure");
  endtask

  task automatic test_extremes();
    for (int i = 0; i <= LEN; i++) begin
      send_word(fill_word(sample_t'(-(1 << (`CORR_WAVE_WIDTH - 1)))));
    end
    for (int i = 0; i <= LEN; i++) begin
      send_word(fill_word(sample_t'((1 << (`CORR_WAVE_WIDTH - 1)) - 1)));
    end
    in_valid <= 1'b0;
    compare_results("extremes");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(2773));
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    test_idle();
    test_impulse();
    test_random_stream();
    test_backpressure();
    test_extremes();
    repeat (50) @(posedge clk);
    if (rx_words.size() != 0) begin
      stop_on_failure("Extra output words arrived after the last test");
    end
    if (i_bit_corr_top.i_checker.assert_fails == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_on_failure("A credit or buffer assertion in the checker failed");
    end
  end

endmodule

// File: tests/bit_corr_checker.sv
// Correlator credit assertions
`timescale 1ns/1ps
`include "corr_cfg.svh"

module bit_corr_checker (
  input logic clk,
  input logic arst_n,
  input logic in_valid,
  input logic in_credit,
  input logic out_valid,
  input logic out_credit,
  input logic entry_push,
  input logic out_pop
);

  // Upstream credits held, downstream credits held, output buffer fill
  int up_credits;
  int dn_credits;
  int out_occ;
  // Read by the testbench
  int assert_fails = 0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      up_credits <= `CORR_IN_DEPTH;
      dn_credits <= `CORR_OUT_CREDITS;
      out_occ    <= 0;
    end else begin
      up_credits <= up_credits - int'(in_valid) + int'(in_credit);
      dn_credits <= dn_credits - int'(out_valid) + int'(out_credit);
      out_occ    <= out_occ + int'(entry_push) - int'(out_pop);
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit rules
  ////////////////////////////////////////////////////////////

  a_in_spend: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> up_credits > 0)
    else begin $error("in_valid without upstream credit"); assert_fails++; end

  a_in_return: assert property (@(posedge clk) disable iff (!arst_n)
    up_credits <= `CORR_IN_DEPTH)
    else begin $error("more in_credit pulses than input slots"); assert_fails++; end

  a_out_spend: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> dn_credits > 0)
    else begin $error("out_valid without downstream credit"); assert_fails++; end

  // Push into a full output buffer
  a_out_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    (entry_push && !out_pop) |-> out_occ < `CORR_OUT_DEPTH)
    else begin $error("output buffer overflow"); assert_fails++; end

endmodule

bind bit_corr_top bit_corr_checker i_checker (
  .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_credit(in_credit),
  .out_valid(out_valid), .out_credit(out_credit), .entry_push(entry_push),
  .out_pop(out_pop)
);

// File: hdl/bit_corr_top.sv
// Streaming bit correlator top
`timescale 1ns/1ps
`include "corr_cfg.svh"

module bit_corr_top
  import corr_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  in_word_t  in_data,
  output logic      in_credit,
  output logic      out_valid,
  output out_word_t out_data,
  output code_idx_t out_code,
  input  logic      out_credit
);

  localparam int OUT_CRED_W = $clog2(`CORR_OUT_CREDITS + 1);

  logic       word_ready;
  in_word_t   word;
  logic       word_pop;
  logic       item_valid;
  sample_t    item_sample;
  chan_idx_t  item_chan;
  code_idx_t  item_code;
  logic       sum_valid;
  acc_t       sum;
  chan_idx_t  sum_chan;
  code_idx_t  sum_code;
  logic       entry_push;
  out_entry_t entry;
  logic       out_ready;
  out_entry_t out_head;
  logic       out_pop;
  logic       space_return;

  logic [OUT_CRED_W-1:0] dn_credit_cnt;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Input buffer, freed slots go back upstream
  credit_fifo #(.DEPTH(`CORR_IN_DEPTH), .payload_t(in_word_t)) i_in_fifo (
    .clk(clk), .arst_n(arst_n), .push(in_valid), .push_data(in_data),
    .rd_pop(word_pop), .rd_ready(word_ready), .rd_data(word), .credit(in_credit)
  );

  corr_sequencer i_sequencer (
    .clk(clk), .arst_n(arst_n), .word_ready(word_ready), .word(word),
    .word_pop(word_pop), .space_return(space_return), .item_valid(item_valid),
    .item_sample(item_sample), .item_chan(item_chan), .item_code(item_code)
  );

  bit_corr_chain i_chain (
    .clk(clk), .arst_n(arst_n), .item_valid(item_valid), .item_sample(item_sample),
    .item_chan(item_chan), .item_code(item_code), .sum_valid(sum_valid),
    .sum(sum), .sum_chan(sum_chan), .sum_code(sum_code)
  );

  corr_collector i_collector (
    .clk(clk), .arst_n(arst_n), .sum_valid(sum_valid), .sum(sum),
    .sum_chan(sum_chan), .sum_code(sum_code), .push(entry_push), .entry(entry)
  );

  // Output buffer, freed slots refund the sequencer
  credit_fifo #(.DEPTH(`CORR_OUT_DEPTH), .payload_t(out_entry_t)) i_out_fifo (
    .clk(clk), .arst_n(arst_n), .push(entry_push), .push_data(entry),
    .rd_pop(out_pop), .rd_ready(out_ready), .rd_data(out_head),
    .credit(space_return)
  );

  ////////////////////////////////////////////////////////////
  // Downstream credits and output stage
  ////////////////////////////////////////////////////////////

  // Send only while downstream has room
  assign out_pop = out_ready && (dn_credit_cnt != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dn_credit_cnt <= OUT_CRED_W'(`CORR_OUT_CREDITS);
      out_valid     <= 1'b0;
    end else begin
      dn_credit_cnt <= dn_credit_cnt - OUT_CRED_W'(out_pop) + OUT_CRED_W'(out_credit);
      out_valid     <= out_pop;
    end
  end

  // Registered word and tag
  always_ff @(posedge clk) begin
    if (out_pop) begin
      out_data <= out_head.word;
      out_code <= out_head.code;
    end
  end

endmodule

// File: hdl/corr_collector.sv
// Correlation sum collector
`timescale 1ns/1ps
`include "corr_cfg.svh"

module corr_collector
  import corr_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sum_valid,
  input  acc_t       sum,
  input  chan_idx_t  sum_chan,
  input  code_idx_t  sum_code,
  output logic       push,
  output out_entry_t entry
);

  localparam int NP = `CORR_NUM_PARALLEL;

  logic last_chan;

  // Final lane of a code
  assign last_chan = sum_valid && (sum_chan == chan_idx_t'(NP - 1));

  ////////////////////////////////////////////////////////////
  // Push strobe
  ////////////////////////////////////////////////////////////

  // Fires the cycle after the last lane lands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push <= 1'b0;
    end else begin
      push <= last_chan;
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry assembly
  ////////////////////////////////////////////////////////////

  // Lane per channel
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      entry.word[sum_chan] <= sum;
    end
  end

  // Tag latched with the last lane
  always_ff @(posedge clk) begin
    if (last_chan) begin
      entry.code <= sum_code;
    end
  end

endmodule

// File: hdl/bit_corr_chain.sv
// Time-multiplexed bit correlator chain
`timescale 1ns/1ps
`include "corr_cfg.svh"

module bit_corr_chain
  import corr_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      item_valid,
  input  sample_t   item_sample,
  input  chan_idx_t item_chan,
  input  code_idx_t item_code,
  output logic      sum_valid,
  output acc_t      sum,
  output chan_idx_t sum_chan,
  output code_idx_t sum_code
);

  localparam int LEN       = `CORR_LENGTH;
  localparam int NP        = `CORR_NUM_PARALLEL;
  localparam int NC        = `CORR_NUM_CORRS;
  localparam int MEM_DEPTH = NP * NC;
  localparam int ADDR_W    = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
  localparam logic [NC*LEN-1:0] TAPS = `CORR_TAPS;

  logic              s1_valid;
  sample_t           s1_sample;
  chan_idx_t         s1_chan;
  code_idx_t         s1_code;
  logic [ADDR_W-1:0] addr;
  logic [LEN-1:0]    code_bits;
  acc_t              sample_ext;

  acc_t add_in0 [LEN];
  acc_t add_in1 [LEN];
  acc_t add_out [LEN];

  // Column n keeps adder n partial sums, one per (code, channel)
  acc_t col_mem [LEN-1][MEM_DEPTH];

  ////////////////////////////////////////////////////////////
  // Item register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= item_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_sample <= item_sample;
    s1_chan   <= item_chan;
    s1_code   <= item_code;
  end

  // Memory address, code major
  assign addr = ADDR_W'(s1_code) * ADDR_W'(NP) + ADDR_W'(s1_chan);

  // Taps of the active code
  assign code_bits  = TAPS[s1_code * LEN +: LEN];
  assign sample_ext = acc_t'(s1_sample);

  ////////////////////////////////////////////////////////////
  // Adders
  ////////////////////////////////////////////////////////////

  for (genvar n = 0; n < LEN; n++) begin : g_adder
    // Reversed tap, since adder n sees the sample LEN-1-n words early
    assign add_in0[n] = code_bits[LEN-1-n] ? sample_ext : -sample_ext;
    if (n == 0) begin : g_first
      assign add_in1[n] = '0;
    end else begin : g_rest
      // Partial sum left by the previous word at this address
      assign add_in1[n] = col_mem[n-1][addr];
    end
    assign add_out[n] = add_in1[n] + add_in0[n];
  end

  ////////////////////////////////////////////////////////////
  // Memory columns
  ////////////////////////////////////////////////////////////

  // Zero history at reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int c = 0; c < LEN - 1; c++) begin
        for (int a = 0; a < MEM_DEPTH; a++) begin
          col_mem[c][a] <= '0;
        end
      end
    end else if (s1_valid) begin
      for (int c = 0; c < LEN - 1; c++) begin
        col_mem[c][addr] <= add_out[c];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Sum register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= s1_valid;
    end
  end

  // Last adder closes the full tap sum
  always_ff @(posedge clk) begin
    sum      <= add_out[LEN-1];
    sum_chan <= s1_chan;
    sum_code <= s1_code;
  end

endmodule

// File: hdl/corr_sequencer.sv
// Correlator item sequencer
`timescale 1ns/1ps
`include "corr_cfg.svh"

module corr_sequencer
  import corr_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      word_ready,
  input  in_word_t  word,
  output logic      word_pop,
  input  logic      space_return,
  output logic      item_valid,
  output sample_t   item_sample,
  output chan_idx_t item_chan,
  output code_idx_t item_code
);

  localparam int NP      = `CORR_NUM_PARALLEL;
  localparam int NC      = `CORR_NUM_CORRS;
  localparam int SPACE_W = $clog2(`CORR_OUT_DEPTH + 1);

  in_word_t         cur_word;
  logic             busy;
  chan_idx_t        chan_cnt;
  code_idx_t        code_cnt;
  logic             last_item;
  logic             space_ok;
  logic [SPACE_W-1:0] space_cnt;
  logic [SPACE_W-1:0] space_charge;
  logic [SPACE_W-1:0] space_refund;

  // Final (channel, code) pair of the batch
  assign last_item = busy && (chan_cnt == chan_idx_t'(NP - 1)) &&
                     (code_cnt == code_idx_t'(NC - 1));

  // Room for a whole batch in the output buffer
  assign space_ok = (space_cnt >= SPACE_W'(NC));

  // Take a word when idle or on the last item, so batches run back to back
  assign word_pop = word_ready && space_ok && (!busy || last_item);

  ////////////////////////////////////////////////////////////
  // Output space accounting
  ////////////////////////////////////////////////////////////

  assign space_charge = word_pop ? SPACE_W'(NC) : '0;
  assign space_refund = space_return ? SPACE_W'(1) : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      space_cnt <= SPACE_W'(`CORR_OUT_DEPTH);
    end else begin
      space_cnt <= space_cnt - space_charge + space_refund;
    end
  end

  ////////////////////////////////////////////////////////////
  // Channel and code walk
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      chan_cnt <= '0;
      code_cnt <= '0;
    end else if (word_pop) begin
      busy     <= 1'b1;
      chan_cnt <= '0;
      code_cnt <= '0;
    end else if (last_item) begin
      busy <= 1'b0;
    end else if (busy) begin
      // Channel fastest, then next code
      if (chan_cnt == chan_idx_t'(NP - 1)) begin
        chan_cnt <= '0;
        code_cnt <= code_cnt + 1'b1;
      end else begin
        chan_cnt <= chan_cnt + 1'b1;
      end
    end
  end

  // Word held for the whole batch
  always_ff @(posedge clk) begin
    if (word_pop) begin
      cur_word <= word;
    end
  end

  // Item taken straight from the walk state
  assign item_valid  = busy;
  assign item_sample = cur_word[chan_cnt];
  assign item_chan   = chan_cnt;
  assign item_code   = code_cnt;

endmodule

// File: hdl/credit_fifo.sv
// Credit-returning circular buffer
`timescale 1ns/1ps

module credit_fifo #(
  parameter int DEPTH = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     rd_pop,
  output logic     rd_ready,
  output payload_t rd_data,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop_ok;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Head word visible whenever something is stored
  assign rd_ready = (count != '0);
  assign rd_data  = mem[rd_ptr];
  // Pop on empty is ignored
  assign pop_ok   = rd_pop & rd_ready;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Writers hold a credit per push, so no full check here
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, occupancy and credit return
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One pulse per freed slot, a cycle after the pop
      credit <= pop_ok;
    end
  end

endmodule

// File: hdl/corr_pkg.sv
// Correlator shared types
`include "corr_cfg.svh"

package corr_pkg;

  // Index widths, kept at one bit minimum
  localparam int CHAN_W = (`CORR_NUM_PARALLEL > 1) ? $clog2(`CORR_NUM_PARALLEL) : 1;
  localparam int CODE_W = (`CORR_NUM_CORRS > 1) ? $clog2(`CORR_NUM_CORRS) : 1;

  ////////////////////////////////////////////////////////////
  // Scalars
  ////////////////////////////////////////////////////////////

  // One input sample, two's complement
  typedef logic signed [`CORR_WAVE_WIDTH-1:0] sample_t;
  // One correlation sum
  typedef logic signed [`CORR_ACC_WIDTH-1:0] acc_t;

  typedef logic [CHAN_W-1:0] chan_idx_t;
  typedef logic [CODE_W-1:0] code_idx_t;

  ////////////////////////////////////////////////////////////
  // Stream words
  ////////////////////////////////////////////////////////////

  // Lane p holds channel p
  typedef sample_t [`CORR_NUM_PARALLEL-1:0] in_word_t;
  typedef acc_t [`CORR_NUM_PARALLEL-1:0] out_word_t;

  // Output buffer payload
  typedef struct packed {
    code_idx_t code;
    out_word_t word;
  } out_entry_t;

endpackage

// File: hdl/corr_cfg.svh
// Correlator size configuration
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

////////////////////////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////////////////////////

// Channels carried in one input word
`define CORR_NUM_PARALLEL 4
`define CORR_WAVE_WIDTH 6
// At least wave width plus bits of the tap count
`define CORR_ACC_WIDTH 12

////////////////////////////////////////////////////////////
// Codes
////////////////////////////////////////////////////////////

`define CORR_NUM_CORRS 2
`define CORR_LENGTH 5
// Code j occupies bits j*LENGTH +: LENGTH, tap 0 at the low end
`define CORR_TAPS 10'b10110_11001

////////////////////////////////////////////////////////////
// Buffers and credits
////////////////////////////////////////////////////////////

// Input slots, same as the upstream starting credit
`define CORR_IN_DEPTH 4
// Must hold at least one full batch of NUM_CORRS entries
`define CORR_OUT_DEPTH 4
`define CORR_OUT_CREDITS 4

`endif
